// File: all.f
logic/rv_decode_pkg.sv
logic/instr_field_decoder.sv
logic/int_reg_file.sv
logic/decode_sequencer.sv
logic/decode_stage.sv
tests/decode_stage_asserts.sv
tests/decode_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# A build error or a stop on a failed assertion also counts as a failure
verilator --binary --timing --assert -f all.f --top-module decode_stage_tb -o sim_decode \
    && ./obj_dir/sim_decode > sim.log 2>&1 \
    || echo "Simulation finished: FAIL" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

// File: tests/decode_stage_tb.sv
// ====================
// Decode stage testbench
// ====================

`timescale 1ns/1ps

module decode_stage_tb;

    localparam int          cycle_limit = 4000;  // About twice the test length
    localparam logic [31:0] seed        = 32'hb7bb_3aee;
    localparam logic [6:0]  f7_zero     = rv_decode_pkg::funct7_zero;
    localparam logic [6:0]  f7_alt      = rv_decode_pkg::funct7_alt;

    // Expected ID/EX contents for one instruction
    typedef struct packed {
        logic [31:0]             op1;
        logic [31:0]             op2;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [4:0]              rd;
        logic                    rs1_read;
        logic                    rs2_read;
        logic                    rd_write;
        logic                    neg;
        logic                    rev;
        logic                    cin;
        logic                    uns;
        logic                    gte;
        rv_decode_pkg::alu_sel_t sel;
        logic                    illegal;
    } exp_t;

    logic                    clk = 1'b0;
    logic                    rstz;
    logic [31:0]             if_ir;
    logic [31:0]             if_pc;
    logic                    if_vld;
    logic                    if_rdy;
    logic                    ex_vld;
    logic                    ex_rdy;
    logic [31:0]             ex_op1;
    logic [31:0]             ex_op2;
    logic [4:0]              ex_rs1;
    logic [4:0]              ex_rs2;
    logic [4:0]              ex_rd;
    logic                    ex_rs1_read;
    logic                    ex_rs2_read;
    logic                    ex_rd_write;
    logic                    ex_alu_neg;
    logic                    ex_alu_rev;
    logic                    ex_alu_cin;
    logic                    ex_alu_uns;
    logic                    ex_alu_gte;
    rv_decode_pkg::alu_sel_t ex_alu_sel;
    logic                    ex_illegal;
    logic                    regwr_en;
    logic [4:0]              regwr_sel;
    logic [31:0]             regwr_data;

    exp_t        exp_q [$];                      // Accepted, not yet consumed
    exp_t        exp_cur;
    logic [31:0] shadow [32];                    // Mirror of the register file
    logic [31:0] rng     = seed;
    logic [31:0] rdy_rng = seed ^ 32'h9e37_79b9; // Own stream for ex_rdy
    logic        bp_on   = 1'b0;
    int          issued, checked, pass_count, fail_count, cycles;

    decode_stage i_dut (.*);

    always #10 clk = ~clk;

    // ====================
    // Helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // ====================
    // Reference decode, RV32I rules for the supported classes
    function automatic exp_t decode_ref(input logic [31:0] ir, input logic [31:0] pc,
                                        input logic [31:0] regs [32]);
        exp_t        e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        is_imm, is_op, is_lui, is_auipc, f7_bad;
        logic [31:0] imm;
        f3       = ir[14:12];
        f7       = ir[31:25];
        is_imm   = ir[6:0] == 7'b0010011;
        is_op    = ir[6:0] == 7'b0110011;
        is_lui   = ir[6:0] == 7'b0110111;
        is_auipc = ir[6:0] == 7'b0010111;
        if (is_op)                                       // Alt only for SUB and SRA
            f7_bad = !(f7 == f7_zero || (f7 == f7_alt && (f3 == 3'd0 || f3 == 3'd5)));
        else if (is_imm && f3 == 3'd1)                   // SLLI
            f7_bad = f7 != f7_zero;
        else if (is_imm && f3 == 3'd5)                   // SRLI or SRAI
            f7_bad = f7 != f7_zero && f7 != f7_alt;
        else
            f7_bad = 1'b0;
        e          = '0;
        e.sel      = rv_decode_pkg::alu_adder;           // ADD unless legal ALU op
        e.illegal  = !(is_imm || is_op || is_lui || is_auipc) || f7_bad;
        e.rd_write = !e.illegal;
        e.rs1_read = is_imm || is_op;
        e.rs2_read = is_op;
        e.rs1      = e.rs1_read ? ir[19:15] : 5'd0;
        e.rs2      = e.rs2_read ? ir[24:20] : 5'd0;
        e.rd       = e.rd_write ? ir[11:7] : 5'd0;
        if ((is_imm || is_op) && !e.illegal) begin
            e.neg = f3 == 3'd2 || f3 == 3'd3 || (f3 == 3'd0 && is_op && f7 == f7_alt);
            e.cin = e.neg || (f3 == 3'd5 && f7 == f7_alt); // Carry in, or SRA sign fill
            e.rev = f3 == 3'd1;                            // SLL via reversal
            e.uns = f3 == 3'd3;
            case (f3)
                3'd0:       e.sel = rv_decode_pkg::alu_adder;
                3'd1, 3'd5: e.sel = rv_decode_pkg::alu_shift;
                3'd2, 3'd3: e.sel = rv_decode_pkg::alu_comp;
                3'd4:       e.sel = rv_decode_pkg::alu_xor;
                3'd6:       e.sel = rv_decode_pkg::alu_or;
                default:    e.sel = rv_decode_pkg::alu_and;
            endcase
        end
        if (is_lui || is_auipc)
            imm = {ir[31:12], 12'd0};
        else
            imm = {{20{ir[31]}}, ir[31:20]};             // I-format, sign extended
        e.op1 = is_lui ? 32'd0 : pc;
        if (e.rs1_read)
            e.op1 = (e.rs1 == 5'd0) ? 32'd0 : regs[e.rs1];
        e.op2 = e.rs2_read ? ((e.rs2 == 5'd0) ? 32'd0 : regs[e.rs2]) : imm;
        return e;
    endfunction

    // ====================
    // Stimulus tasks, called 1 ns after a rising edge
    task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
        regwr_en   = 1'b1;
        regwr_sel  = sel;
        regwr_data = data;
        @(posedge clk);
        #1;
        regwr_en    = 1'b0;
        shadow[sel] = data;                              // x0 kept too, reads as zero
    endtask

    task automatic issue(input logic [31:0] ir, input logic [31:0] pc);
        if_ir  = ir;
        if_pc  = pc;
        if_vld = 1'b1;
        @(negedge clk);
        while (!if_rdy) @(negedge clk);                  // Transfer on next rising edge
        exp_q.push_back(decode_ref(ir, pc, shadow));
        issued++;
        @(posedge clk);
        #1;
        if_vld = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
        $display("Test %0d %s: done, %0d failures so far", num, name, fail_count);
    endtask

    // ====================
    // Back-pressure, random only in test 6
    always @(posedge clk) begin
        #1;
        if (bp_on) begin
            rdy_rng = xorshift32(rdy_rng);
            ex_rdy  = rdy_rng[7];
        end else begin
            ex_rdy = 1'b1;
        end
    end

    // Compare mid-cycle, one record per consumed output
    always @(negedge clk) begin
        if (rstz && ex_vld && ex_rdy) begin
            checked++;                                   // Every consumed output
            if (exp_q.size() == 0) begin
                $display("Output at %0t ns with no instruction outstanding", $time);
                fail_count++;
            end else begin
                exp_cur = exp_q.pop_front();
                check_value("ex_illegal", 32'(exp_cur.illegal), 32'(ex_illegal));
                check_value("ex_rd_write", 32'(exp_cur.rd_write), 32'(ex_rd_write));
                check_value("ex_rs1_read", 32'(exp_cur.rs1_read), 32'(ex_rs1_read));
                check_value("ex_rs2_read", 32'(exp_cur.rs2_read), 32'(ex_rs2_read));
                check_value("ex_rs1", 32'(exp_cur.rs1), 32'(ex_rs1));
                check_value("ex_rs2", 32'(exp_cur.rs2), 32'(ex_rs2));
                check_value("ex_rd", 32'(exp_cur.rd), 32'(ex_rd));
                check_value("ex_alu_neg", 32'(exp_cur.neg), 32'(ex_alu_neg));
                check_value("ex_alu_rev", 32'(exp_cur.rev), 32'(ex_alu_rev));
                check_value("ex_alu_cin", 32'(exp_cur.cin), 32'(ex_alu_cin));
                check_value("ex_alu_uns", 32'(exp_cur.uns), 32'(ex_alu_uns));
                check_value("ex_alu_gte", 32'(exp_cur.gte), 32'(ex_alu_gte));
                check_value("ex_alu_sel", 32'(exp_cur.sel), 32'(ex_alu_sel));
                if (!exp_cur.illegal) begin               // Operands only for legal ops
                    check_value("ex_op1", exp_cur.op1, ex_op1);
                    check_value("ex_op2", exp_cur.op2, ex_op2);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles without completing the tests", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ====================
    // Test sequence
    initial begin
        logic [31:0] r;
        logic [6:0]  f7;
        rstz       = 1'b0;
        if_ir      = 32'd0;
        if_pc      = 32'd0;
        if_vld     = 1'b0;
        ex_rdy     = 1'b1;
        regwr_en   = 1'b0;
        regwr_sel  = 5'd0;
        regwr_data = 32'd0;
        repeat (8) @(posedge clk);
        #1;
        rstz = 1'b1;
        for (int i = 0; i < 32; i++) write_reg(5'(i), next_random());

        repeat (150) begin                               // OP, register changes between
            r = next_random();
            write_reg(r[4:0], next_random());
            r  = next_random();
            f7 = (r[30] && (r[14:12] == 3'd0 || r[14:12] == 3'd5)) ? f7_alt : f7_zero;
            issue({f7, r[24:7], 7'b0110011}, next_random() & ~32'd3);
        end
        finish_test(1, "OP");

        repeat (150) begin                               // OP-IMM, half negative
            r  = next_random();
            f7 = r[31:25];
            if (r[14:12] == 3'd1) f7 = f7_zero;          // SLLI
            if (r[14:12] == 3'd5) f7 = r[0] ? f7_alt : f7_zero;
            issue({f7, r[24:7], 7'b0010011}, next_random() & ~32'd3);
        end
        finish_test(2, "OP-IMM");

        repeat (40) begin
            r = next_random();
            issue({r[31:7], r[0] ? 7'b0110111 : 7'b0010111}, next_random() & ~32'd3);
        end
        finish_test(3, "LUI and AUIPC");

        r = next_random();
        issue(32'h0000_0000, 32'h200);                   // Opcode all zeros
        issue(32'hffff_ffff, 32'h204);                   // Opcode all ones
        issue({r[31:7], 7'b0010001}, 32'h208);           // Low bits 01
        issue({r[31:7], 7'b0000011}, 32'h20c);           // LOAD
        issue({r[31:7], 7'b0100011}, 32'h210);           // STORE
        issue({r[31:7], 7'b1100011}, 32'h214);           // BRANCH
        issue({r[31:7], 7'b1101111}, 32'h218);           // JAL
        issue({r[31:7], 7'b1110011}, 32'h21c);           // SYSTEM
        issue({f7_alt, r[24:15], 3'd1, r[11:7], 7'b0110011}, 32'h220);
        issue({7'd1, r[24:15], 3'd0, r[11:7], 7'b0110011}, 32'h224);   // M extension
        issue({f7_alt, r[24:15], 3'd1, r[11:7], 7'b0010011}, 32'h228); // SLLI alt
        issue({7'd1, r[24:15], 3'd5, r[11:7], 7'b0010011}, 32'h22c);
        finish_test(4, "illegal encodings");

        write_reg(5'd0, 32'hdead_beef);                  // Stored but never visible
        issue({f7_zero, 5'd0, 5'd0, 3'd0, 5'd5, 7'b0110011}, 32'h300);
        issue({12'h7ff, 5'd0, 3'd0, 5'd6, 7'b0010011}, 32'h304);
        finish_test(5, "x0 reads zero");

        bp_on = 1'b1;
        repeat (250) begin                               // Back to back, if_vld held
            r = next_random();
            issue({r[31:7], r[0] ? 7'b0010011 : 7'b0110111}, next_random() & ~32'd3);
        end
        bp_on = 1'b0;
        finish_test(6, "back-pressure");
        repeat (4) @(posedge clk);                       // Late extra outputs still counted
        check_value("instructions_checked", 32'(issued), 32'(checked));

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: tests/decode_stage_asserts.sv
// ====================
// Sequencer assertions
// ====================

`timescale 1ns/1ps

module decode_stage_asserts (
    input logic        clk,
    input logic        rstz,
    input logic        in_operand,
    input logic        if_vld,
    input logic        if_rdy,
    input logic        ex_vld,
    input logic        ex_rdy,
    input logic [90:0] ex_payload  // Every ex_ output but ex_vld
);

    // Accept leads to one blocked operand cycle, then valid output
    operand_blocks_accept: assert property (@(posedge clk) disable iff (!rstz)
        if_vld && if_rdy |=> (in_operand && !if_rdy) ##1 ex_vld)
        else $error("accept not followed by a blocked operand cycle and valid output");

    // Stalled output holds
    stall_holds_output: assert property (@(posedge clk) disable iff (!rstz)
        ex_vld && !ex_rdy |=> ex_vld && $stable(ex_payload))
        else $error("ex_ outputs changed while stalled");

    reset_clears_valid: assert property (@(posedge clk)
        !rstz |=> !ex_vld)
        else $error("ex_vld high right after reset");

endmodule

bind decode_sequencer decode_stage_asserts i_asserts (
    .clk        (clk),
    .rstz       (rstz),
    .in_operand (state == id_operand),
    .if_vld     (if_vld),
    .if_rdy     (if_rdy),
    .ex_vld     (ex_vld),
    .ex_rdy     (ex_rdy),
    .ex_payload ({ex_op1, ex_op2, ex_rs1, ex_rs2, ex_rd, ex_rs1_read, ex_rs2_read,
                  ex_rd_write, ex_alu_neg, ex_alu_rev, ex_alu_cin, ex_alu_uns,
                  ex_alu_gte, ex_alu_sel, ex_illegal})
);

// File: logic/decode_stage.sv
// ====================
// RV32I decode stage
// ====================

`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rstz,
    // Fetch side
    input  logic [31:0]             if_ir,
    input  logic [31:0]             if_pc,
    input  logic                    if_vld,
    output logic                    if_rdy,
    // Execute side
    output logic                    ex_vld,
    input  logic                    ex_rdy,
    output logic [31:0]             ex_op1,
    output logic [31:0]             ex_op2,
    output logic [4:0]              ex_rs1,
    output logic [4:0]              ex_rs2,
    output logic [4:0]              ex_rd,
    output logic                    ex_rs1_read,
    output logic                    ex_rs2_read,
    output logic                    ex_rd_write,
    output logic                    ex_alu_neg,
    output logic                    ex_alu_rev,
    output logic                    ex_alu_cin,
    output logic                    ex_alu_uns,
    output logic                    ex_alu_gte,
    output rv_decode_pkg::alu_sel_t ex_alu_sel,
    output logic                    ex_illegal,
    // Write-back
    input  logic                    regwr_en,
    input  logic [4:0]              regwr_sel,
    input  logic [31:0]             regwr_data
);

    logic                    alu_neg, alu_rev, alu_cin, alu_uns, alu_gte;
    rv_decode_pkg::alu_sel_t alu_sel;
    logic                    rs1_read, rs2_read, rd_write, op1_zero, illegal;
    logic [31:0]             immediate;
    logic                    read_en;
    logic [31:0]             rs1_data, rs2_data;

    // ====================
    // Decoder and regfile both look at if_ir
    instr_field_decoder i_decoder (
        .ir        (if_ir),
        .alu_neg   (alu_neg),
        .alu_rev   (alu_rev),
        .alu_cin   (alu_cin),
        .alu_uns   (alu_uns),
        .alu_gte   (alu_gte),
        .alu_sel   (alu_sel),
        .rs1_read  (rs1_read),
        .rs2_read  (rs2_read),
        .rd_write  (rd_write),
        .op1_zero  (op1_zero),
        .immediate (immediate),
        .illegal   (illegal)
    );

    int_reg_file i_regfile (
        .clk        (clk),
        .rstz       (rstz),
        .read_en    (read_en),
        .rs1        (if_ir[19:15]),
        .rs2        (if_ir[24:20]),
        .regwr_en   (regwr_en),
        .regwr_sel  (regwr_sel),
        .regwr_data (regwr_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    // Merges both into ID/EX
    decode_sequencer i_sequencer (
        .clk         (clk),
        .rstz        (rstz),
        .if_vld      (if_vld),
        .if_pc       (if_pc),
        .if_rdy      (if_rdy),
        .alu_neg     (alu_neg),
        .alu_rev     (alu_rev),
        .alu_cin     (alu_cin),
        .alu_uns     (alu_uns),
        .alu_gte     (alu_gte),
        .alu_sel     (alu_sel),
        .rs1_read    (rs1_read),
        .rs2_read    (rs2_read),
        .rd_write    (rd_write),
        .op1_zero    (op1_zero),
        .immediate   (immediate),
        .illegal     (illegal),
        .rs1         (if_ir[19:15]),
        .rs2         (if_ir[24:20]),
        .rd          (if_ir[11:7]),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .read_en     (read_en),
        .ex_vld      (ex_vld),
        .ex_rdy      (ex_rdy),
        .ex_op1      (ex_op1),
        .ex_op2      (ex_op2),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_rs1_read (ex_rs1_read),
        .ex_rs2_read (ex_rs2_read),
        .ex_rd_write (ex_rd_write),
        .ex_alu_neg  (ex_alu_neg),
        .ex_alu_rev  (ex_alu_rev),
        .ex_alu_cin  (ex_alu_cin),
        .ex_alu_uns  (ex_alu_uns),
        .ex_alu_gte  (ex_alu_gte),
        .ex_alu_sel  (ex_alu_sel),
        .ex_illegal  (ex_illegal)
    );

endmodule

// File: logic/decode_sequencer.sv
// ====================
// Decode sequencer
// ====================

`timescale 1ns/1ps

module decode_sequencer (
    input  logic                    clk,
    input  logic                    rstz,
    // Fetch side
    input  logic                    if_vld,
    input  logic [31:0]             if_pc,
    output logic                    if_rdy,
    // From field decoder
    input  logic                    alu_neg,
    input  logic                    alu_rev,
    input  logic                    alu_cin,
    input  logic                    alu_uns,
    input  logic                    alu_gte,
    input  rv_decode_pkg::alu_sel_t alu_sel,
    input  logic                    rs1_read,
    input  logic                    rs2_read,
    input  logic                    rd_write,
    input  logic                    op1_zero,
    input  logic [31:0]             immediate,
    input  logic                    illegal,
    // Register indices and read data
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic [31:0]             rs1_data,
    input  logic [31:0]             rs2_data,
    output logic                    read_en,
    // Execute side
    output logic                    ex_vld,
    input  logic                    ex_rdy,
    output logic [31:0]             ex_op1,
    output logic [31:0]             ex_op2,
    output logic [4:0]              ex_rs1,
    output logic [4:0]              ex_rs2,
    output logic [4:0]              ex_rd,
    output logic                    ex_rs1_read,
    output logic                    ex_rs2_read,
    output logic                    ex_rd_write,
    output logic                    ex_alu_neg,
    output logic                    ex_alu_rev,
    output logic                    ex_alu_cin,
    output logic                    ex_alu_uns,
    output logic                    ex_alu_gte,
    output rv_decode_pkg::alu_sel_t ex_alu_sel,
    output logic                    ex_illegal
);

    typedef enum logic {
        id_accept,  // Waiting for an instruction
        id_operand  // Register data arrives
    } seq_state_t;

    seq_state_t state, next_state;
    logic       transfer;

    // Accept only when the ID/EX slot is empty or draining
    assign if_rdy   = (state == id_accept) && (!ex_vld || ex_rdy);
    assign transfer = if_vld && if_rdy;
    assign read_en  = transfer; // Regfile samples on the accept edge

    // ====================
    // State register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) state <= id_accept;
        else       state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            id_accept:  if (transfer) next_state = id_operand;
            id_operand: next_state = id_accept; // Always one cycle
            default:    next_state = id_accept;
        endcase
    end

    // Output valid
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ex_vld <= 1'b0;
        end else if (transfer) begin
            ex_vld <= 1'b0;                  // Slot refilled, not yet complete
        end else if (state == id_operand) begin
            ex_vld <= 1'b1;
        end else if (ex_vld && ex_rdy) begin
            ex_vld <= 1'b0;                  // Consumed, nothing new
        end
    end

    // ====================
    // ID/EX payload
    // Controls on accept, operands finished one cycle later
    always_ff @(posedge clk) begin
        if (transfer) begin
            ex_alu_neg  <= alu_neg;
            ex_alu_rev  <= alu_rev;
            ex_alu_cin  <= alu_cin;
            ex_alu_uns  <= alu_uns;
            ex_alu_gte  <= alu_gte;
            ex_alu_sel  <= alu_sel;
            ex_illegal  <= illegal;
            ex_rs1_read <= rs1_read;
            ex_rs2_read <= rs2_read;
            ex_rd_write <= rd_write;
            ex_rs1      <= rs1_read ? rs1 : 5'd0; // Unused index reads as x0
            ex_rs2      <= rs2_read ? rs2 : 5'd0;
            ex_rd       <= rd_write ? rd  : 5'd0;
            ex_op1      <= op1_zero ? 32'd0 : if_pc;
            ex_op2      <= immediate;              // Replaced by rs2 for OP
        end else if (state == id_operand) begin
            if (ex_rs1_read) ex_op1 <= rs1_data;
            if (ex_rs2_read) ex_op2 <= rs2_data;
        end
    end

endmodule

// File: logic/int_reg_file.sv
// ====================
// Integer register file
// ====================

`timescale 1ns/1ps

module int_reg_file (
    input  logic        clk,
    input  logic        rstz,
    input  logic        read_en,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        regwr_en,
    input  logic [4:0]  regwr_sel,
    input  logic [31:0] regwr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // Mirrored banks, one per read port
    logic [31:0] bank_a [32];
    logic [31:0] bank_b [32];

    // Write port updates both copies, x0 included
    always_ff @(posedge clk) begin
        if (regwr_en) begin
            bank_a[regwr_sel] <= regwr_data;
            bank_b[regwr_sel] <= regwr_data;
        end
    end

    // ====================
    // Registered reads on accept
    // x0 always reads zero
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rs1_data <= 32'd0;
            rs2_data <= 32'd0;
        end else if (read_en) begin
            rs1_data <= (rs1 == 5'd0) ? 32'd0 : bank_a[rs1]; // Old data on same-edge write
            rs2_data <= (rs2 == 5'd0) ? 32'd0 : bank_b[rs2];
        end
    end

endmodule

// File: logic/instr_field_decoder.sv
// ====================
// RV32I field decoder
// ====================

`timescale 1ns/1ps

module instr_field_decoder (
    input  logic [31:0]            ir,
    output logic                   alu_neg,
    output logic                   alu_rev,
    output logic                   alu_cin,
    output logic                   alu_uns,
    output logic                   alu_gte,
    output rv_decode_pkg::alu_sel_t alu_sel,
    output logic                   rs1_read,
    output logic                   rs2_read,
    output logic                   rd_write,
    output logic                   op1_zero,
    output logic [31:0]            immediate,
    output logic                   illegal
);

    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    rv_decode_pkg::opcode_class_t opcode_class;
    logic                         opcode_ok;   // Not all zeros/ones, low bits 11
    logic                         class_ok;    // Supported class
    logic                         is_alu;      // OP-IMM or OP
    logic                         bad_funct7;
    logic                         f7_zero, f7_alt;
    logic                         format_i, format_u;
    logic                         sign;

    assign opcode       = ir[6:0];
    assign funct3       = ir[14:12];
    assign funct7       = ir[31:25];
    assign opcode_class = rv_decode_pkg::opcode_class_t'({ir[6:5], ir[4:2]});

    assign opcode_ok = (opcode != 7'h00) && (opcode != 7'h7f) && (ir[1:0] == 2'b11);
    assign f7_zero   = funct7 == rv_decode_pkg::funct7_zero;
    assign f7_alt    = funct7 == rv_decode_pkg::funct7_alt;

    // ====================
    // Class decode
    always_comb begin
        class_ok = 1'b0;
        is_alu   = 1'b0;
        rs1_read = 1'b0;
        rs2_read = 1'b0;
        op1_zero = 1'b0;
        format_i = 1'b0;
        format_u = 1'b0;
        if (opcode_ok) begin
            case (opcode_class)
                rv_decode_pkg::instr_opimm: begin
                    class_ok = 1'b1;
                    is_alu   = 1'b1;
                    rs1_read = 1'b1;
                    format_i = 1'b1;
                end
                rv_decode_pkg::instr_op: begin
                    class_ok = 1'b1;
                    is_alu   = 1'b1;
                    rs1_read = 1'b1;
                    rs2_read = 1'b1;
                end
                rv_decode_pkg::instr_lui: begin
                    class_ok = 1'b1;
                    op1_zero = 1'b1; // rd = 0 + imm
                    format_u = 1'b1;
                end
                rv_decode_pkg::instr_auipc: begin
                    class_ok = 1'b1;
                    format_u = 1'b1; // rd = pc + imm
                end
                default: class_ok = 1'b0;
            endcase
        end
    end

    // funct7 legality, OP allows alt only on ADD/SUB and SRL/SRA
    always_comb begin
        bad_funct7 = 1'b0;
        if (is_alu && opcode_class == rv_decode_pkg::instr_op) begin
            bad_funct7 = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
        end else if (is_alu) begin
            if (funct3 == 3'b001) bad_funct7 = !f7_zero;          // SLLI
            if (funct3 == 3'b101) bad_funct7 = !(f7_zero || f7_alt); // SRLI/SRAI
        end
    end

    assign illegal  = !opcode_ok || !class_ok || bad_funct7;
    assign rd_write = !illegal;

    // ====================
    // ALU controls, ADD unless a legal ALU op says otherwise
    always_comb begin
        alu_neg = 1'b0;
        alu_rev = 1'b0;
        alu_cin = 1'b0;
        alu_uns = 1'b0;
        alu_gte = 1'b0; // No branch compares in this stage
        alu_sel = rv_decode_pkg::alu_adder;
        if (is_alu && !illegal) begin
            case (funct3)
                3'b000: begin // ADD/ADDI, SUB on OP with alt
                    if (opcode_class == rv_decode_pkg::instr_op && f7_alt) begin
                        alu_neg = 1'b1;
                        alu_cin = 1'b1;
                    end
                end
                3'b001: begin // SLL
                    alu_rev = 1'b1;
                    alu_sel = rv_decode_pkg::alu_shift;
                end
                3'b010: begin // SLT
                    alu_neg = 1'b1;
                    alu_cin = 1'b1;
                    alu_sel = rv_decode_pkg::alu_comp;
                end
                3'b011: begin // SLTU
                    alu_neg = 1'b1;
                    alu_cin = 1'b1;
                    alu_uns = 1'b1;
                    alu_sel = rv_decode_pkg::alu_comp;
                end
                3'b100:  alu_sel = rv_decode_pkg::alu_xor;
                3'b101: begin // SRL, SRA when cin fills sign
                    alu_cin = f7_alt;
                    alu_sel = rv_decode_pkg::alu_shift;
                end
                3'b110:  alu_sel = rv_decode_pkg::alu_or;
                default: alu_sel = rv_decode_pkg::alu_and;
            endcase
        end
    end

    // ====================
    // Immediate, I or U format from six segments
    assign sign = ir[31];
    assign immediate = {
        format_u ? ir[31:20] : {12{sign}},  // [31:20]
        format_u ? ir[19:12] : {8{sign}},   // [19:12]
        format_u ? 1'b0      : sign,        // [11]
        format_u ? 6'd0      : ir[30:25],   // [10:5]
        format_u ? 4'd0      : ir[24:21],   // [4:1]
        format_i ? ir[20]    : 1'b0         // [0]
    };

endmodule

// File: logic/rv_decode_pkg.sv
// ====================
// RV32I decode types
// ====================

package rv_decode_pkg;

    // ====================
    // Opcode class
    // Taken from ir[6:5] and ir[4:2] together
    typedef enum logic [4:0] {
        instr_opimm = 5'b00_100, // Register-immediate ALU ops
        instr_auipc = 5'b00_101, // PC plus upper immediate
        instr_op    = 5'b01_100, // Register-register ALU ops
        instr_lui   = 5'b01_101  // Upper immediate into rd
    } opcode_class_t;

    // ====================
    // ALU result select
    typedef enum logic [2:0] {
        alu_adder = 3'd0, // Add, sub, default
        alu_and   = 3'd1,
        alu_or    = 3'd2,
        alu_xor   = 3'd3,
        alu_comp  = 3'd4, // Set less than, signed or unsigned
        alu_shift = 3'd5  // Left shift goes through bit reversal
    } alu_sel_t;

    // ====================
    // funct7 encodings
    localparam logic [6:0] funct7_zero = 7'd0;  // Base op
    localparam logic [6:0] funct7_alt  = 7'd32; // SUB and SRA/SRAI

endpackage
